// File: rtl/gr_pkg.sv
package gr_pkg;

	// Register file geometry
	localparam int NUM_PREG = 64;
	localparam int NUM_LREG = 32;

	// Field widths
	localparam int PREG_W = $clog2(NUM_PREG);
	localparam int LREG_W = $clog2(NUM_LREG);
	localparam int TAG_W = 6;
	localparam int WORD_W = 32;

	// Physical register name
	typedef logic [PREG_W-1:0] preg_t;

	// Logical (architectural) register name
	typedef logic [LREG_W-1:0] lreg_t;

	// Commit tag handed out by the reorder buffer
	typedef logic [TAG_W-1:0] tag_t;

	// Register value
	typedef logic [WORD_W-1:0] word_t;

	// One commit flag per commit tag
	typedef logic [(1 << TAG_W)-1:0] commit_vec_t;

	// Free name count, 0 up to NUM_PREG inclusive
	typedef logic [$clog2(NUM_PREG+1)-1:0] fl_count_t;

	// Entry life cycle
	// RESET     waiting for the first clock after reset
	// INIT      holds the architectural state of one logical register
	// FREELIST  unmapped, asking the free list for a slot
	// RESERVE   queued as free or mapped by rename
	typedef enum logic [1:0] {
		ST_RESET,
		ST_INIT,
		ST_FREELIST,
		ST_RESERVE
	} entry_state_t;

endpackage

// File: rtl/gr_read_port.sv
`timescale 1ns/1ps

module gr_read_port (
	input  gr_pkg::preg_t rd_preg,
	input  logic [gr_pkg::NUM_PREG-1:0] valid_bus,
	input  logic [gr_pkg::NUM_PREG*gr_pkg::WORD_W-1:0] data_bus,
	output logic rd_valid,
	output gr_pkg::word_t rd_data
);
	import gr_pkg::*;

	word_t words [NUM_PREG];

	// Split the flat bus into one word per physical register
	always_comb begin
		for (int i = 0; i < NUM_PREG; i++) begin
			words[i] = data_bus[i*WORD_W +: WORD_W];
		end
	end

	// Availability and value of the addressed register
	assign rd_valid = valid_bus[rd_preg];
	assign rd_data = words[rd_preg];

endmodule

// File: rtl/gr_free_list.sv
`timescale 1ns/1ps

module gr_free_list #(
	parameter int FL_DEPTH = 64
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic restart,
	input  logic [gr_pkg::NUM_PREG-1:0] req,
	output logic [gr_pkg::NUM_PREG-1:0] grant,
	input  logic [1:0] pop,
	output logic free0_valid,
	output gr_pkg::preg_t free0_preg,
	output logic free1_valid,
	output gr_pkg::preg_t free1_preg,
	output gr_pkg::fl_count_t free_count
);
	import gr_pkg::*;

	localparam int PTR_W = $clog2(FL_DEPTH);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FL_DEPTH - 1);

	preg_t mem [FL_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_ptr_1;
	fl_count_t count;
	logic full;
	logic push;
	preg_t pick;

	// Circular increment that also handles depths other than powers of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == LAST_PTR) ? '0 : PTR_W'(p + 1'b1);
	endfunction

	// Lowest-indexed requester wins
	always_comb begin
		pick = '0;
		for (int i = NUM_PREG - 1; i >= 0; i--) begin
			if (req[i]) begin
				pick = preg_t'(i);
			end
		end
	end

	assign full = (count == fl_count_t'(FL_DEPTH));
	assign push = (|req) && !full && !restart;
	assign grant = push ? ({{(NUM_PREG-1){1'b0}}, 1'b1} << pick) : '0;

	assign rd_ptr_1 = ptr_next(rd_ptr);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (restart) begin
			// Entries request again, so the queue just starts over
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop == 2'd1) begin
				rd_ptr <= rd_ptr_1;
			end else if (pop == 2'd2) begin
				rd_ptr <= ptr_next(rd_ptr_1);
			end
			count <= count + fl_count_t'(push) - fl_count_t'(pop);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= pick;
		end
	end

	// Head and second slot for the two rename lanes
	assign free0_valid = (count != '0);
	assign free1_valid = (count > fl_count_t'(1));
	assign free0_preg = mem[rd_ptr];
	assign free1_preg = mem[rd_ptr_1];
	assign free_count = count;

	a_pop_limit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fl_count_t'(pop) <= free_count)
		else $error("rename popped %0d names with %0d free", pop, free_count);

	// A granted entry has left the free state by the next cycle
	a_grant_drops_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(|grant) |=> ((req & $past(grant)) == '0))
		else $error("granted entry still requesting a free list slot");

endmodule

// File: rtl/gr_entry.sv
`timescale 1ns/1ps

module gr_entry #(
	parameter gr_pkg::preg_t ENTRY_ID = '0
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic restart,
	input  gr_pkg::commit_vec_t commit_vector,
	input  logic reg0_valid,
	input  gr_pkg::preg_t reg0_preg,
	input  gr_pkg::lreg_t reg0_lreg,
	input  gr_pkg::tag_t reg0_tag,
	input  logic reg1_valid,
	input  gr_pkg::preg_t reg1_preg,
	input  gr_pkg::lreg_t reg1_lreg,
	input  gr_pkg::tag_t reg1_tag,
	input  logic exe_add_valid,
	input  gr_pkg::tag_t exe_add_tag,
	input  gr_pkg::word_t exe_add_data,
	input  logic exe_mul_valid,
	input  gr_pkg::tag_t exe_mul_tag,
	input  gr_pkg::word_t exe_mul_data,
	input  logic exe_ldst_valid,
	input  gr_pkg::tag_t exe_ldst_tag,
	input  gr_pkg::word_t exe_ldst_data,
	input  logic freelist_grant,
	output logic freelist_req,
	output logic data_valid,
	output gr_pkg::word_t data
);
	import gr_pkg::*;

	// Low IDs start out as the architectural registers
	localparam logic IS_ARCH = (ENTRY_ID < NUM_LREG);

	entry_state_t state;

	// Current mapping
	logic cur_valid;
	tag_t cur_tag;
	lreg_t cur_lreg;
	logic cur_exe_end;
	word_t cur_data;
	logic cur_commit;

	// Next (younger) mapping of the same logical register
	logic nxt_valid;
	tag_t nxt_tag;
	logic nxt_exe_end;
	logic nxt_commit;

	logic init_load;
	logic claim0;
	logic claim1;
	logic next0;
	logic next1;
	logic cur_capture;
	logic release_now;
	logic nxt_clear;

	function automatic logic tag_done(input tag_t t);
		return (exe_add_valid && exe_add_tag == t) ||
			(exe_mul_valid && exe_mul_tag == t) ||
			(exe_ldst_valid && exe_ldst_tag == t);
	endfunction

	assign init_load = (state == ST_RESET) && IS_ARCH;
	assign claim0 = reg0_valid && (reg0_preg == ENTRY_ID);
	assign claim1 = reg1_valid && (reg1_preg == ENTRY_ID);

	// Port 1 is younger, so it can rename what port 0 just put here
	assign next0 = reg0_valid && cur_valid && (reg0_lreg == cur_lreg);
	assign next1 = reg1_valid && ((cur_valid && (reg1_lreg == cur_lreg)) ||
		(claim0 && (reg1_lreg == reg0_lreg)));

	assign cur_capture = cur_valid && !cur_exe_end && tag_done(cur_tag);

	// Back to the free list once superseded and retired, or squashed
	assign release_now = ((state == ST_INIT || state == ST_RESERVE) &&
		cur_commit && nxt_commit) ||
		((state == ST_RESERVE) && restart && !cur_commit);
	assign nxt_clear = release_now || (restart && !nxt_commit);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_RESET;
		end else begin
			case (state)
				ST_RESET: begin
					state <= IS_ARCH ? ST_INIT : ST_FREELIST;
				end
				ST_FREELIST: begin
					if (freelist_grant && !restart) begin
						state <= ST_RESERVE;
					end
				end
				default: begin
					if (release_now) begin
						state <= ST_FREELIST;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cur_valid <= 1'b0;
			cur_exe_end <= 1'b0;
			cur_commit <= 1'b0;
		end else if (release_now) begin
			cur_valid <= 1'b0;
			cur_exe_end <= 1'b0;
			cur_commit <= 1'b0;
		end else begin
			if (init_load || claim0 || claim1) begin
				cur_valid <= 1'b1;
			end
			if (init_load || cur_capture) begin
				cur_exe_end <= 1'b1;
			end
			// Architectural state is retired by definition
			if (state == ST_INIT && cur_valid) begin
				cur_commit <= 1'b1;
			end else if (cur_valid && cur_exe_end && !cur_commit) begin
				cur_commit <= commit_vector[cur_tag];
			end
		end
	end

	// Mapping fields and result
	always_ff @(posedge iCLOCK) begin
		if (init_load) begin
			cur_tag <= '0;
			cur_lreg <= lreg_t'(ENTRY_ID);
		end else if (claim0) begin
			cur_tag <= reg0_tag;
			cur_lreg <= reg0_lreg;
		end else if (claim1) begin
			cur_tag <= reg1_tag;
			cur_lreg <= reg1_lreg;
		end
		if (init_load) begin
			cur_data <= '0;
		end else if (cur_capture) begin
			if (exe_add_valid && exe_add_tag == cur_tag) begin
				cur_data <= exe_add_data;
			end else if (exe_mul_valid && exe_mul_tag == cur_tag) begin
				cur_data <= exe_mul_data;
			end else begin
				cur_data <= exe_ldst_data;
			end
		end
		if (!nxt_valid && next0) begin
			nxt_tag <= reg0_tag;
		end else if (!nxt_valid && next1) begin
			nxt_tag <= reg1_tag;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			nxt_valid <= 1'b0;
			nxt_exe_end <= 1'b0;
			nxt_commit <= 1'b0;
		end else if (nxt_clear) begin
			nxt_valid <= 1'b0;
			nxt_exe_end <= 1'b0;
			nxt_commit <= 1'b0;
		end else begin
			// First rename only, later ones retire after it anyway
			if (!nxt_valid && (next0 || next1)) begin
				nxt_valid <= 1'b1;
			end
			if (nxt_valid && tag_done(nxt_tag)) begin
				nxt_exe_end <= 1'b1;
			end
			if (nxt_valid && nxt_exe_end && !nxt_commit) begin
				nxt_commit <= commit_vector[nxt_tag];
			end
		end
	end

	assign freelist_req = (state == ST_FREELIST) && !restart;
	assign data_valid = cur_exe_end && !nxt_exe_end;
	assign data = cur_data;

	// The free list must have seen the request drop
	a_no_grant_reserve: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(state == ST_RESERVE) |-> !freelist_grant)
		else $error("grant to entry %0d while reserved", ENTRY_ID);

	a_free_unmapped: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(state == ST_FREELIST) |-> !cur_valid)
		else $error("entry %0d free but still mapped", ENTRY_ID);

endmodule

// File: rtl/gr_scheduler_top.sv
`timescale 1ns/1ps

module gr_scheduler_top #(
	parameter int FL_DEPTH = 64
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic restart,
	input  gr_pkg::commit_vec_t commit_vector,
	input  logic reg0_valid,
	input  gr_pkg::preg_t reg0_preg,
	input  gr_pkg::lreg_t reg0_lreg,
	input  gr_pkg::tag_t reg0_tag,
	input  logic reg1_valid,
	input  gr_pkg::preg_t reg1_preg,
	input  gr_pkg::lreg_t reg1_lreg,
	input  gr_pkg::tag_t reg1_tag,
	input  logic exe_add_valid,
	input  gr_pkg::tag_t exe_add_tag,
	input  gr_pkg::word_t exe_add_data,
	input  logic exe_mul_valid,
	input  gr_pkg::tag_t exe_mul_tag,
	input  gr_pkg::word_t exe_mul_data,
	input  logic exe_ldst_valid,
	input  gr_pkg::tag_t exe_ldst_tag,
	input  gr_pkg::word_t exe_ldst_data,
	input  logic [1:0] pop,
	output logic free0_valid,
	output gr_pkg::preg_t free0_preg,
	output logic free1_valid,
	output gr_pkg::preg_t free1_preg,
	output gr_pkg::fl_count_t free_count,
	input  gr_pkg::preg_t rd0_preg,
	output logic rd0_valid,
	output gr_pkg::word_t rd0_data,
	input  gr_pkg::preg_t rd1_preg,
	output logic rd1_valid,
	output gr_pkg::word_t rd1_data
);
	import gr_pkg::*;

	logic [NUM_PREG-1:0] fl_req;
	logic [NUM_PREG-1:0] fl_grant;
	logic [NUM_PREG-1:0] valid_bus;
	logic [NUM_PREG*WORD_W-1:0] data_bus;

	// One entry per physical register
	for (genvar i = 0; i < NUM_PREG; i++) begin : g_entry
		gr_entry #(
			.ENTRY_ID(preg_t'(i))
		) u_entry (
			.iCLOCK(iCLOCK),
			.inRESET(inRESET),
			.restart(restart),
			.commit_vector(commit_vector),
			.reg0_valid(reg0_valid),
			.reg0_preg(reg0_preg),
			.reg0_lreg(reg0_lreg),
			.reg0_tag(reg0_tag),
			.reg1_valid(reg1_valid),
			.reg1_preg(reg1_preg),
			.reg1_lreg(reg1_lreg),
			.reg1_tag(reg1_tag),
			.exe_add_valid(exe_add_valid),
			.exe_add_tag(exe_add_tag),
			.exe_add_data(exe_add_data),
			.exe_mul_valid(exe_mul_valid),
			.exe_mul_tag(exe_mul_tag),
			.exe_mul_data(exe_mul_data),
			.exe_ldst_valid(exe_ldst_valid),
			.exe_ldst_tag(exe_ldst_tag),
			.exe_ldst_data(exe_ldst_data),
			.freelist_grant(fl_grant[i]),
			.freelist_req(fl_req[i]),
			.data_valid(valid_bus[i]),
			.data(data_bus[i*WORD_W +: WORD_W])
		);
	end

	gr_free_list #(
		.FL_DEPTH(FL_DEPTH)
	) u_free_list (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.req(fl_req),
		.grant(fl_grant),
		.pop(pop),
		.free0_valid(free0_valid),
		.free0_preg(free0_preg),
		.free1_valid(free1_valid),
		.free1_preg(free1_preg),
		.free_count(free_count)
	);

	// Two operand reads per cycle
	gr_read_port u_rd0 (
		.rd_preg(rd0_preg),
		.valid_bus(valid_bus),
		.data_bus(data_bus),
		.rd_valid(rd0_valid),
		.rd_data(rd0_data)
	);

	gr_read_port u_rd1 (
		.rd_preg(rd1_preg),
		.valid_bus(valid_bus),
		.data_bus(data_bus),
		.rd_valid(rd1_valid),
		.rd_data(rd1_data)
	);

endmodule

// File: verification/tb_gr_tasks.svh
task automatic abort_run(input string why);
	$display("%s", why);
	$display("Something failed");
	$fatal(1, "run stopped at first error");
endtask

task automatic check_preg(input string name, input preg_t got, input preg_t exp);
	if (got !== exp) begin
		abort_run($sformatf("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		abort_run($sformatf("FAILED at %0t: %s = 0x%08h, expected 0x%08h",
			$time, name, got, exp));
	end
endtask

task automatic check_count(input string name, input fl_count_t got, input fl_count_t exp);
	if (got !== exp) begin
		abort_run($sformatf("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
	end
endtask

task automatic next_cycle();
	@(posedge iCLOCK);
	#2;
endtask

task automatic init_inputs();
	restart = 1'b0;
	commit_vector = '0;
	reg0_valid = 1'b0;
	reg0_preg = '0;
	reg0_lreg = '0;
	reg0_tag = '0;
	reg1_valid = 1'b0;
	reg1_preg = '0;
	reg1_lreg = '0;
	reg1_tag = '0;
	exe_add_valid = 1'b0;
	exe_add_tag = '0;
	exe_add_data = '0;
	exe_mul_valid = 1'b0;
	exe_mul_tag = '0;
	exe_mul_data = '0;
	exe_ldst_valid = 1'b0;
	exe_ldst_tag = '0;
	exe_ldst_data = '0;
	pop = 2'd0;
	rd0_preg = '0;
	rd1_preg = '0;
endtask

// Free list outputs against the model queue
task automatic check_head();
	check_count("free_count", free_count, fl_count_t'(free_q.size()));
	check_bit("free0_valid", free0_valid, free_q.size() > 0);
	check_bit("free1_valid", free1_valid, free_q.size() > 1);
	if (free_q.size() > 0) begin
		check_preg("free0_preg", free0_preg, free_q[0]);
	end
	if (free_q.size() > 1) begin
		check_preg("free1_preg", free1_preg, free_q[1]);
	end
endtask

task automatic wait_for_count(input fl_count_t exp, input int limit);
	int n;
	n = 0;
	while (free_count !== exp && n < limit) begin
		next_cycle();
		n++;
	end
	if (free_count !== exp) begin
		abort_run($sformatf("free_count stuck at %0d, did not reach %0d within %0d cycles",
			free_count, exp, limit));
	end
endtask

// Pops every queued name, one per cycle, in model order
task automatic drain_free_list();
	while (free_q.size() > 0) begin
		check_head();
		pop = 2'd1;
		void'(free_q.pop_front());
		next_cycle();
		pop = 2'd0;
	end
	check_head();
endtask

task automatic pulse_restart();
	restart = 1'b1;
	commit_vector = '0;
	free_q.delete();
	next_cycle();
	restart = 1'b0;
endtask

task automatic rename_one(input lreg_t l0, input tag_t t0, output preg_t p0);
	check_head();
	p0 = free_q.pop_front();
	reg0_valid = 1'b1;
	reg0_preg = p0;
	reg0_lreg = l0;
	reg0_tag = t0;
	pop = 2'd1;
	next_cycle();
	reg0_valid = 1'b0;
	pop = 2'd0;
endtask

// Port 1 is the younger of the two
task automatic rename_pair(input lreg_t l0, input tag_t t0, input lreg_t l1, input tag_t t1,
	output preg_t p0, output preg_t p1);
	check_head();
	p0 = free_q.pop_front();
	p1 = free_q.pop_front();
	reg0_valid = 1'b1;
	reg0_preg = p0;
	reg0_lreg = l0;
	reg0_tag = t0;
	reg1_valid = 1'b1;
	reg1_preg = p1;
	reg1_lreg = l1;
	reg1_tag = t1;
	pop = 2'd2;
	next_cycle();
	reg0_valid = 1'b0;
	reg1_valid = 1'b0;
	pop = 2'd0;
endtask

task automatic set_exec(input int unit, input tag_t t, input word_t d);
	case (unit)
		UNIT_ADD: begin
			exe_add_valid = 1'b1;
			exe_add_tag = t;
			exe_add_data = d;
		end
		UNIT_MUL: begin
			exe_mul_valid = 1'b1;
			exe_mul_tag = t;
			exe_mul_data = d;
		end
		default: begin
			exe_ldst_valid = 1'b1;
			exe_ldst_tag = t;
			exe_ldst_data = d;
		end
	endcase
endtask

task automatic clear_exec();
	exe_add_valid = 1'b0;
	exe_mul_valid = 1'b0;
	exe_ldst_valid = 1'b0;
endtask

// One register on each read port
task automatic check_read_two(input preg_t p0, input logic v0, input word_t d0,
	input preg_t p1, input logic v1, input word_t d1);
	next_cycle();
	rd0_preg = p0;
	rd1_preg = p1;
	#1;
	check_bit($sformatf("rd0_valid (preg %0d)", p0), rd0_valid, v0);
	check_bit($sformatf("rd1_valid (preg %0d)", p1), rd1_valid, v1);
	if (v0) begin
		check_word($sformatf("rd0_data (preg %0d)", p0), rd0_data, d0);
	end
	if (v1) begin
		check_word($sformatf("rd1_data (preg %0d)", p1), rd1_data, d1);
	end
endtask

// Same register on both read ports
task automatic check_read(input preg_t p, input logic exp_valid, input word_t exp_data);
	check_read_two(p, exp_valid, exp_data, p, exp_valid, exp_data);
endtask

task automatic after_reset();
	check_head();
	wait_for_count(fl_count_t'(32), 34);
	for (int i = NUM_LREG; i < NUM_PREG; i++) begin
		free_q.push_back(preg_t'(i));
	end
	drain_free_list();
	for (int i = 0; i < NUM_LREG; i++) begin
		check_read(preg_t'(i), 1'b1, '0);
	end
	// Popped names are unmapped and restart hands them back in order
	pulse_restart();
	wait_for_count(fl_count_t'(32), 34);
	for (int i = NUM_LREG; i < NUM_PREG; i++) begin
		free_q.push_back(preg_t'(i));
	end
	check_head();
endtask

task automatic dual_rename();
	preg_t pa;
	preg_t pb;
	word_t da;
	word_t db;
	da = $urandom();
	db = $urandom();
	rename_pair(5'd1, 6'd1, 5'd2, 6'd2, pa, pb);
	set_exec(UNIT_ADD, 6'd1, da);
	set_exec(UNIT_LDST, 6'd2, db);
	next_cycle();
	clear_exec();
	check_read_two(pa, 1'b1, da, pb, 1'b1, db);
	check_read_two(pb, 1'b1, db, pa, 1'b1, da);
	// Old copies of r1 and r2 are superseded
	check_read_two(preg_t'(1), 1'b0, '0, pa, 1'b1, da);
	check_read_two(pb, 1'b1, db, preg_t'(2), 1'b0, '0);
endtask

task automatic three_units();
	preg_t p3;
	preg_t p4;
	preg_t p5;
	word_t d3;
	word_t d4;
	word_t d5;
	d3 = $urandom();
	d4 = $urandom();
	d5 = $urandom();
	rename_pair(5'd3, 6'd3, 5'd4, 6'd4, p3, p4);
	rename_one(5'd5, 6'd5, p5);
	set_exec(UNIT_ADD, 6'd3, d3);
	set_exec(UNIT_MUL, 6'd4, d4);
	set_exec(UNIT_LDST, 6'd5, d5);
	next_cycle();
	clear_exec();
	check_read(p3, 1'b1, d3);
	check_read(p4, 1'b1, d4);
	check_read(p5, 1'b1, d5);
endtask

task automatic release_on_commit();
	preg_t p;
	word_t dv;
	dv = $urandom();
	rename_one(5'd6, 6'd6, p);
	set_exec(UNIT_ADD, 6'd6, dv);
	next_cycle();
	clear_exec();
	// Nothing retired yet
	repeat (6) next_cycle();
	check_head();
	commit_vector[6] = 1'b1;
	wait_for_count(fl_count_t'(free_q.size() + 1), 6);
	free_q.push_back(preg_t'(6));
	arch_map[6] = p;
	arch_val[6] = dv;
	// p has no younger mapping and must stay
	repeat (6) next_cycle();
	check_head();
	check_read(p, 1'b1, dv);
endtask

task automatic same_lreg_pair();
	preg_t pa;
	preg_t pb;
	word_t da;
	word_t db;
	da = $urandom();
	db = $urandom();
	rename_pair(5'd7, 6'd7, 5'd7, 6'd8, pa, pb);
	set_exec(UNIT_MUL, 6'd7, da);
	set_exec(UNIT_LDST, 6'd8, db);
	next_cycle();
	clear_exec();
	check_read(preg_t'(7), 1'b0, '0);
	check_read(pa, 1'b0, '0);
	check_read(pb, 1'b1, db);
	commit_vector[7] = 1'b1;
	commit_vector[8] = 1'b1;
	// Old r7 and the port-0 register come back in index order
	wait_for_count(fl_count_t'(free_q.size() + 2), 8);
	free_q.push_back(preg_t'(7));
	free_q.push_back(pa);
	arch_map[7] = pb;
	arch_val[7] = db;
	repeat (6) next_cycle();
	check_head();
	check_read(pb, 1'b1, db);
	drain_free_list();
endtask

task automatic restart_rebuild();
	logic [NUM_PREG-1:0] held;
	held = '0;
	for (int l = 0; l < NUM_LREG; l++) begin
		held[arch_map[l]] = 1'b1;
	end
	pulse_restart();
	// Everything outside the committed map is free again
	for (int i = 0; i < NUM_PREG; i++) begin
		if (!held[i]) begin
			free_q.push_back(preg_t'(i));
		end
	end
	wait_for_count(fl_count_t'(free_q.size()), 34);
	drain_free_list();
	for (int l = 0; l < NUM_LREG; l++) begin
		check_read(arch_map[l], 1'b1, arch_val[l]);
	end
endtask

// File: verification/tb_gr_scheduler.sv
`timescale 1ns/1ps

module tb_gr_scheduler;
	import gr_pkg::*;

	// Tests need about 400 cycles, the rest is margin
	localparam int MAX_CYCLES = 2000;
	localparam int SEED = 34691;

	// Execution unit select
	localparam int UNIT_ADD = 0;
	localparam int UNIT_MUL = 1;
	localparam int UNIT_LDST = 2;

	logic iCLOCK;
	logic inRESET;
	logic restart;
	commit_vec_t commit_vector;
	logic reg0_valid;
	preg_t reg0_preg;
	lreg_t reg0_lreg;
	tag_t reg0_tag;
	logic reg1_valid;
	preg_t reg1_preg;
	lreg_t reg1_lreg;
	tag_t reg1_tag;
	logic exe_add_valid;
	tag_t exe_add_tag;
	word_t exe_add_data;
	logic exe_mul_valid;
	tag_t exe_mul_tag;
	word_t exe_mul_data;
	logic exe_ldst_valid;
	tag_t exe_ldst_tag;
	word_t exe_ldst_data;
	logic [1:0] pop;
	logic free0_valid;
	preg_t free0_preg;
	logic free1_valid;
	preg_t free1_preg;
	fl_count_t free_count;
	preg_t rd0_preg;
	logic rd0_valid;
	word_t rd0_data;
	preg_t rd1_preg;
	logic rd1_valid;
	word_t rd1_data;

	// Reference model: queued free names and the committed map table
	preg_t free_q[$];
	preg_t arch_map[NUM_LREG];
	word_t arch_val[NUM_LREG];
	int cycles = 0;

	gr_scheduler_top #(
		.FL_DEPTH(64)
	) dut0 (.*);

	`include "tb_gr_tasks.svh"

	always #20 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			abort_run($sformatf("Timeout: run still going after %0d cycles", cycles));
		end
	end

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		init_inputs();
		void'($urandom(SEED));
		for (int l = 0; l < NUM_LREG; l++) begin
			arch_map[l] = preg_t'(l);
			arch_val[l] = '0;
		end
		repeat (10) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;

		after_reset();
		dual_rename();
		three_units();
		release_on_commit();
		same_lreg_pair();
		restart_rebuild();

		$display("Everything OK");
		$finish;
	end

endmodule

// File: files.f
+incdir+verification
rtl/gr_pkg.sv
rtl/gr_read_port.sv
rtl/gr_free_list.sv
rtl/gr_entry.sv
rtl/gr_scheduler_top.sv
verification/tb_gr_scheduler.sv

// File: Makefile
TOP = tb_gr_scheduler
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
